// ==== sources.f ====
verilog/iq_pkg.sv
verilog/dispatch_stage.sv
verilog/age_select.sv
verilog/issue_queue.sv
verilog/issue_top.sv
verif/issue_tb_assert.sv
verif/issue_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module issue_tb -f sources.f
out=$(./obj_dir/Vissue_tb || true)
echo "$out"
if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== verif/issue_tb.sv ====
`timescale 1ns/1ns

module issue_tb
	import iq_pkg::*;
();

	localparam int QS = 8;
	localparam int RAND_CYCLES = 300;
	// every tag woken once, then the queue empties
	localparam int DRAIN = 80;
	localparam int TOTAL_CYCLES = 16 + 6 * DRAIN + 1 + 8 + 10 + 5 * QS + (QS + 1)
		+ RAND_CYCLES;

	logic clk = 1'b0;
	logic rst_i = 1'b1;
	logic dispatch_i = 1'b0;
	uop_t dispatch_uop_i = '0;
	logic wake_i = 1'b0;
	tag_t wake_tag_i = '0;
	logic issue_valid_o;
	uop_t issue_uop_o;
	logic full_o;

	// queued entries in dispatch order, plus the dispatch register
	uop_t model_q[$];
	int seq_q[$];
	logic pend_v = 1'b0;
	uop_t pend_uop;
	int pend_seq;
	logic exp_valid = 1'b0;
	uop_t exp_uop;
	logic exp_full = 1'b0;
	logic hold = 1'b0;

	logic [31:0] lfsr_q = 32'ha568;
	string test_name = "reset";
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int dispatched = 0;
	int issued = 0;

	issue_top #(
		.QUEUE_SIZE(QS)
	) issue_top_inst (
		.clk(clk),
		.rst_i(rst_i),
		.dispatch_i(dispatch_i),
		.dispatch_uop_i(dispatch_uop_i),
		.wake_i(wake_i),
		.wake_tag_i(wake_tag_i),
		.issue_valid_o(issue_valid_o),
		.issue_uop_o(issue_uop_o),
		.full_o(full_o)
	);

	always #2 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic uop_t make_uop(tag_t src, logic rdy);
		uop_t u;
		u.dst_tag = tag_t'(take_bits(TAG_W));
		u.src_tag = src;
		u.src_ready = rdy;
		u.payload = payload_t'(take_bits(PAYLOAD_W));
		return u;
	endfunction

	function automatic uop_t woken(uop_t u, logic w, tag_t t);
		uop_t r;
		r = u;
		if (w && u.src_tag == t) begin
			r.src_ready = 1'b1;
		end
		return r;
	endfunction

	// oldest queued entry with a ready source, -1 if none
	function automatic int ref_pick();
		for (int i = 0; i < model_q.size(); i++) begin
			if (model_q[i].src_ready) begin
				return i;
			end
		end
		return -1;
	endfunction

	// select on the old state, then wake, then move the dispatch register in
	always @(posedge clk) begin
		int pick;
		if (!rst_i) begin
			pick = ref_pick();
			exp_valid = (pick >= 0);
			if (pick >= 0) begin
				exp_uop = model_q[pick];
				model_q.delete(pick);
				seq_q.delete(pick);
			end
			foreach (model_q[i]) begin
				model_q[i] = woken(model_q[i], wake_i, wake_tag_i);
			end
			if (pend_v) begin
				model_q.push_back(woken(pend_uop, wake_i, wake_tag_i));
				seq_q.push_back(pend_seq);
			end
			pend_v = dispatch_i;
			if (dispatch_i) begin
				pend_uop = woken(dispatch_uop_i, wake_i, wake_tag_i);
				pend_seq = dispatched;
				dispatched++;
			end
			exp_full = (model_q.size() + int'(pend_v)) >= QS;
			// age tags only order entries less than QS dispatches apart
			hold = exp_full || (seq_q.size() > 0 && dispatched - seq_q[0] >= QS);
		end
	end

	task automatic check_bit(string what, logic exp, logic act);
		if (act !== exp) begin
			$display("[ERROR] %s %s: expected %b actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_uop(string what, uop_t exp, uop_t act);
		if (act !== exp) begin
			$display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (!rst_i) begin
			check_bit("issue_valid_o", exp_valid, issue_valid_o);
			check_bit("full_o", exp_full, full_o);
			if (exp_valid && issue_valid_o) begin
				check_uop("issue_uop_o", exp_uop, issue_uop_o);
			end
			if (issue_valid_o) begin
				issued++;
			end
		end
	end

	task automatic drive(logic d, uop_t u, logic w, tag_t t);
		@(posedge clk);
		#1;
		dispatch_i = d && !hold;
		dispatch_uop_i = u;
		wake_i = w;
		wake_tag_i = t;
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_errors = errors;
	endtask

	// wake every tag in turn until the model is empty
	task automatic end_test();
		int t;
		t = 0;
		while (model_q.size() != 0 || pend_v || exp_valid) begin
			drive(1'b0, '0, 1'b1, tag_t'(t));
			t = (t + 1) % 64;
		end
		drive(1'b0, '0, 1'b0, '0);
		tests_run++;
		$display("%s done, %0d errors", test_name, errors - test_errors);
	endtask

	initial begin
		uop_t u;
		logic d;
		logic w;
		tag_t wt;
		repeat (16) @(posedge clk);
		#1;
		rst_i = 1'b0;

		start_test("ready_latency");
		drive(1'b1, make_uop(tag_t'(3), 1'b1), 1'b0, '0);
		end_test();

		start_test("wakeup");
		drive(1'b1, make_uop(tag_t'(5), 1'b0), 1'b0, '0);
		for (int k = 0; k < 6; k++) begin
			drive(1'b0, '0, 1'b1, tag_t'(9 + k));
		end
		drive(1'b0, '0, 1'b1, tag_t'(5));
		end_test();

		start_test("age_order");
		for (int k = 0; k < 4; k++) begin
			drive(1'b1, make_uop(tag_t'(k), 1'b1), 1'b0, '0);
		end
		for (int k = 0; k < 5; k++) begin
			drive(1'b1, make_uop(tag_t'(7), 1'b0), 1'b0, '0);
		end
		drive(1'b0, '0, 1'b1, tag_t'(7));
		end_test();

		start_test("age_wrap");
		// groups of three, the older pair shares a tag
		for (int k = 0; k < 3 * QS; k++) begin
			drive(1'b1, make_uop(tag_t'((k % 3 == 2) ? 11 : 10), 1'b0), 1'b0, '0);
			// newest of the group wakes first, then the older pair together
			if (k % 3 == 2) begin
				drive(1'b0, '0, 1'b1, tag_t'(11));
				drive(1'b0, '0, 1'b1, tag_t'(10));
			end
		end
		end_test();

		start_test("full");
		for (int k = 0; k < QS; k++) begin
			drive(1'b1, make_uop(tag_t'(20 + k), 1'b0), 1'b0, '0);
		end
		drive(1'b0, '0, 1'b1, tag_t'(23));
		end_test();

		start_test("random_mix");
		for (int k = 0; k < RAND_CYCLES; k++) begin
			u = make_uop(tag_t'(take_bits(3)), take_bits(2) == 0);
			d = take_bits(1) == 1;
			w = take_bits(2) == 0;
			wt = tag_t'(take_bits(3));
			drive(d, u, w, wt);
		end
		end_test();

		if (dispatched != issued) begin
			$display("%0d micro-ops were dispatched but %0d issued", dispatched, issued);
		end
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0 && dispatched == issued) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * 4 * 2);
		$display("watchdog expired during test %s", test_name);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== verif/issue_tb_assert.sv ====
`timescale 1ns/1ns

module issue_tb_assert
	import iq_pkg::*;
(
	input logic clk,
	input logic rst_i,
	input logic dispatch_i,
	input logic full_o,
	input logic issue_valid_o,
	input uop_t issue_uop_o
);

	// issue register is cleared by the async reset
	a_quiet_in_reset: assert property (@(posedge clk) rst_i |-> !issue_valid_o)
		else $error("issue_valid_o high during reset");

	a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst_i)
		full_o |-> !dispatch_i)
		else $error("dispatch_i raised while full_o is high");

	a_issue_ready: assert property (@(posedge clk) disable iff (rst_i)
		issue_valid_o |-> issue_uop_o.src_ready)
		else $error("issued micro-op has no ready source");

endmodule

bind issue_top issue_tb_assert issue_tb_assert_inst (
	.clk(clk),
	.rst_i(rst_i),
	.dispatch_i(dispatch_i),
	.full_o(full_o),
	.issue_valid_o(issue_valid_o),
	.issue_uop_o(issue_uop_o)
);

// ==== verilog/issue_top.sv ====
`timescale 1ns/1ns

module issue_top
	import iq_pkg::*;
#(
	parameter int QUEUE_SIZE = QUEUE_SIZE_DEF
) (
	input logic clk,
	input logic rst_i,
	input logic dispatch_i,
	input uop_t dispatch_uop_i,
	input logic wake_i,
	input tag_t wake_tag_i,
	output logic issue_valid_o,
	output uop_t issue_uop_o,
	output logic full_o
);

	localparam int AGE_W = $clog2(QUEUE_SIZE) + 1;

	// dispatch register to queue
	logic pend_valid;
	uop_t pend_uop;
	logic [AGE_W-1:0] pend_age;

	dispatch_stage #(
		.QUEUE_SIZE(QUEUE_SIZE)
	) dispatch_stage_inst (
		.clk(clk),
		.rst_i(rst_i),
		.dispatch_i(dispatch_i),
		.dispatch_uop_i(dispatch_uop_i),
		.wake_i(wake_i),
		.wake_tag_i(wake_tag_i),
		.pend_valid_o(pend_valid),
		.pend_uop_o(pend_uop),
		.pend_age_o(pend_age)
	);

	issue_queue #(
		.QUEUE_SIZE(QUEUE_SIZE)
	) issue_queue_inst (
		.clk(clk),
		.rst_i(rst_i),
		.pend_valid_i(pend_valid),
		.pend_uop_i(pend_uop),
		.pend_age_i(pend_age),
		.wake_i(wake_i),
		.wake_tag_i(wake_tag_i),
		.issue_valid_o(issue_valid_o),
		.issue_uop_o(issue_uop_o),
		.full_o(full_o)
	);

endmodule

// ==== verilog/issue_queue.sv ====
`timescale 1ns/1ns

module issue_queue
	import iq_pkg::*;
#(
	parameter int QUEUE_SIZE = QUEUE_SIZE_DEF
) (
	input logic clk,
	input logic rst_i,
	input logic pend_valid_i,
	input uop_t pend_uop_i,
	input logic [$clog2(QUEUE_SIZE):0] pend_age_i,
	input logic wake_i,
	input tag_t wake_tag_i,
	output logic issue_valid_o,
	output uop_t issue_uop_o,
	output logic full_o
);

	localparam int IDX_W = $clog2(QUEUE_SIZE);
	localparam int AGE_W = IDX_W + 1;
	localparam int CNT_W = $clog2(QUEUE_SIZE + 1);

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [AGE_W-1:0] age_t;
	typedef logic [CNT_W-1:0] cnt_t;

	// entry contents, the valid bit lives apart
	typedef struct packed {
		uop_t uop;
		age_t age;
	} slot_t;

	logic [QUEUE_SIZE-1:0] valid_q;
	slot_t slot_q [QUEUE_SIZE];
	cnt_t count_q;

	idx_t alloc_idx;
	logic [QUEUE_SIZE-1:0] sel_en;
	age_t [QUEUE_SIZE-1:0] sel_age;
	logic sel_any;
	idx_t sel_idx;

	logic issue_valid_q;
	uop_t issue_uop_q;

	// lowest-numbered free slot
	always_comb begin
		alloc_idx = '0;
		for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				alloc_idx = idx_t'(i);
			end
		end
	end

	// candidates are valid entries with a ready source
	always_comb begin
		for (int i = 0; i < QUEUE_SIZE; i++) begin
			sel_en[i] = valid_q[i] & slot_q[i].uop.src_ready;
			sel_age[i] = slot_q[i].age;
		end
	end

	age_select #(
		.QUEUE_SIZE(QUEUE_SIZE),
		.AGE_W(AGE_W)
	) age_select_inst (
		.en_i(sel_en),
		.age_i(sel_age),
		.any_o(sel_any),
		.idx_o(sel_idx)
	);

	// issued slot is still valid here, so it is never the allocated one
	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (sel_any) begin
				valid_q[sel_idx] <= 1'b0;
			end
			if (pend_valid_i) begin
				valid_q[alloc_idx] <= 1'b1;
			end
		end
	end

	// write or wake each slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_SIZE; i++) begin
			if (pend_valid_i && (alloc_idx == idx_t'(i))) begin
				slot_q[i].uop <= apply_wake(pend_uop_i, wake_i, wake_tag_i);
				slot_q[i].age <= pend_age_i;
			end else begin
				slot_q[i].uop <= apply_wake(slot_q[i].uop, wake_i, wake_tag_i);
			end
		end
	end

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + cnt_t'(pend_valid_i) - cnt_t'(sel_any);
		end
	end

	// pending uop already claims a slot
	assign full_o = ({1'b0, count_q} + {{CNT_W{1'b0}}, pend_valid_i})
		>= (CNT_W + 1)'(QUEUE_SIZE);

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			issue_valid_q <= 1'b0;
		end else begin
			issue_valid_q <= sel_any;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_any) begin
			issue_uop_q <= slot_q[sel_idx].uop;
		end
	end

	assign issue_valid_o = issue_valid_q;
	assign issue_uop_o = issue_uop_q;

endmodule

// ==== verilog/age_select.sv ====
`timescale 1ns/1ns

module age_select
	import iq_pkg::*;
#(
	parameter int QUEUE_SIZE = QUEUE_SIZE_DEF,
	// age width stays that of the full queue down the tree
	parameter int AGE_W = $clog2(QUEUE_SIZE) + 1
) (
	input logic [QUEUE_SIZE-1:0] en_i,
	input logic [QUEUE_SIZE-1:0][AGE_W-1:0] age_i,
	output logic any_o,
	output logic [((QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1)-1:0] idx_o
);

	localparam int IDX_W = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

	generate
		if (QUEUE_SIZE == 1) begin : g_leaf
			assign any_o = en_i[0];
			assign idx_o = '0;
		end else begin : g_node
			localparam int LO = QUEUE_SIZE / 2;
			localparam int HI = QUEUE_SIZE - LO;
			localparam int LO_W = (LO > 1) ? $clog2(LO) : 1;
			localparam int HI_W = (HI > 1) ? $clog2(HI) : 1;

			logic lo_any;
			logic hi_any;
			logic [LO_W-1:0] lo_idx;
			logic [HI_W-1:0] hi_idx;
			logic [IDX_W-1:0] hi_pos;
			logic [AGE_W-1:0] lo_age;
			logic [AGE_W-1:0] hi_age;
			logic hi_older;
			logic pick_hi;

			age_select #(
				.QUEUE_SIZE(LO),
				.AGE_W(AGE_W)
			) lo_sel (
				.en_i(en_i[LO-1:0]),
				.age_i(age_i[LO-1:0]),
				.any_o(lo_any),
				.idx_o(lo_idx)
			);

			age_select #(
				.QUEUE_SIZE(HI),
				.AGE_W(AGE_W)
			) hi_sel (
				.en_i(en_i[QUEUE_SIZE-1:LO]),
				.age_i(age_i[QUEUE_SIZE-1:LO]),
				.any_o(hi_any),
				.idx_o(hi_idx)
			);

			// winner ages fetched back from the full array
			assign hi_pos = IDX_W'(LO) + IDX_W'(hi_idx);
			assign lo_age = age_i[lo_idx];
			assign hi_age = age_i[hi_pos];

			// smaller counter is older, flipped when the wrap bits differ
			assign hi_older = (hi_age[0] ^ lo_age[0]) ^
				(hi_age[AGE_W-1:1] < lo_age[AGE_W-1:1]);

			// disabled side always loses
			assign pick_hi = hi_any & (~lo_any | hi_older);
			assign any_o = lo_any | hi_any;
			assign idx_o = pick_hi ? hi_pos : IDX_W'(lo_idx);
		end
	endgenerate

endmodule

// ==== verilog/dispatch_stage.sv ====
`timescale 1ns/1ns

module dispatch_stage
	import iq_pkg::*;
#(
	parameter int QUEUE_SIZE = QUEUE_SIZE_DEF
) (
	input logic clk,
	input logic rst_i,
	input logic dispatch_i,
	input uop_t dispatch_uop_i,
	input logic wake_i,
	input tag_t wake_tag_i,
	output logic pend_valid_o,
	output uop_t pend_uop_o,
	output logic [$clog2(QUEUE_SIZE):0] pend_age_o
);

	localparam int IDX_W = $clog2(QUEUE_SIZE);

	typedef logic [IDX_W-1:0] idx_t;
	// counter in the upper bits, wrap bit at bit 0
	typedef logic [IDX_W:0] age_t;

	idx_t age_cnt_q;
	logic age_wrap_q;
	logic pend_valid_q;
	uop_t pend_uop_q;
	age_t pend_age_q;

	// age counter wraps at QUEUE_SIZE and flips the wrap bit
	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			age_cnt_q <= '0;
			age_wrap_q <= 1'b0;
		end else if (dispatch_i) begin
			if (age_cnt_q == idx_t'(QUEUE_SIZE - 1)) begin
				age_cnt_q <= '0;
				age_wrap_q <= ~age_wrap_q;
			end else begin
				age_cnt_q <= age_cnt_q + idx_t'(1);
			end
		end
	end

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			pend_valid_q <= 1'b0;
		end else begin
			pend_valid_q <= dispatch_i;
		end
	end

	// a broadcast in the dispatch cycle must not be lost
	always_ff @(posedge clk) begin
		if (dispatch_i) begin
			pend_uop_q <= apply_wake(dispatch_uop_i, wake_i, wake_tag_i);
			pend_age_q <= {age_cnt_q, age_wrap_q};
		end
	end

	assign pend_valid_o = pend_valid_q;
	assign pend_uop_o = pend_uop_q;
	assign pend_age_o = pend_age_q;

endmodule

// ==== verilog/iq_pkg.sv ====
package iq_pkg;

	// default queue depth, the top level overrides it
	localparam int QUEUE_SIZE_DEF = 8;

	// physical register tag and opaque micro-op bits
	localparam int TAG_W = 6;
	localparam int PAYLOAD_W = 16;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [PAYLOAD_W-1:0] payload_t;

	// one source operand only
	typedef struct packed {
		tag_t dst_tag;
		tag_t src_tag;
		logic src_ready;
		payload_t payload;
	} uop_t;

	// result broadcast marks the source ready on a tag match
	function automatic uop_t apply_wake(uop_t uop, logic wake, tag_t tag);
		uop_t res;
		res = uop;
		if (wake && (uop.src_tag == tag)) begin
			res.src_ready = 1'b1;
		end
		return res;
	endfunction

endpackage
